//--- hw/osd_pkg.sv
// shared OSD types and constants; OSD runs at half clk, only 5 host commands decoded, no memory access
package osd_pkg;

  // --------------------------------------------------
  // widths that carry a meaning
  // --------------------------------------------------

  // one word from the host port
  typedef logic [15:0] host_word_t;

  // data word index within a command, saturating
  typedef logic [2:0] dat_cnt_t;

  // character buffer address and contents
  typedef logic [10:0] buf_addr_t;
  typedef logic [7:0] buf_byte_t;

  // beam counters, horizontal in clk units
  typedef logic [10:0] hbeam_t;
  typedef logic [8:0] vbeam_t;

  // video config, top to bottom: blver, ar, dither, hr_filter, lr_filter, scanline
  typedef logic [11:0] video_cfg_t;

  // --------------------------------------------------
  // host command codes, bits 7..2 of a command word
  // --------------------------------------------------

  // codes not listed here select nothing
  typedef enum logic [5:0] {
    CMD_RESET_CTRL = 6'b0_000_10,
    CMD_OSD_CTRL   = 6'b0_010_10,
    CMD_VIDEO_CFG  = 6'b0_011_01,
    CMD_OSD_BUFFER = 6'b0_000_11,
    CMD_VERSION    = 6'b1_000_10
  } cmd_code_t;

  // host word sequencing
  typedef enum logic [1:0] {
    ST_IDLE,
    ST_CMD,
    ST_DATA
  } host_state_t;

  // --------------------------------------------------
  // constants
  // --------------------------------------------------

  localparam int WAIT_CYCLES = 5;
  localparam dat_cnt_t DAT_CNT_MAX = 3'd4;
  // word 3 of a buffer write carries the line number
  localparam dat_cnt_t BUF_LINE_WORD = 3'd3;

  // OSD window, horizontal in half-clock units
  localparam logic [9:0] OSD_H_START = 10'd448;
  localparam logic [9:0] OSD_H_WIDTH = 10'd256;
  localparam vbeam_t OSD_V_START = 9'd128;
  localparam vbeam_t OSD_V_HEIGHT = 9'd64;

  // beta flag, major, minor, minion
  localparam buf_byte_t VERSION_BYTES [0:3] = '{8'h01, 8'h03, 8'h05, 8'h02};

endpackage

//--- hw/osd_cmd_if.sv
// one received host word with its command context; rx is a single-cycle pulse per word
`timescale 1ns/1ps

interface osd_cmd_if;

  // word strobe and command/data flag
  logic rx;
  logic is_cmd;
  // word contents, valid while rx is high
  osd_pkg::host_word_t word;
  // command latched from the last command word
  osd_pkg::cmd_code_t cmd;
  // index of this data word within the command
  osd_pkg::dat_cnt_t dat_cnt;

  // host FSM side
  modport driver (
    output rx,
    output is_cmd,
    output word,
    output cmd,
    output dat_cnt
  );

  // register and buffer side
  modport receiver (
    input rx,
    input is_cmd,
    input word,
    input cmd,
    input dat_cnt
  );

endinterface

//--- hw/osd_host_fsm.sv
// host word sequencer; the host must not strobe while io_wait is high, no back-pressure beyond that
`timescale 1ns/1ps

module osd_host_fsm (
  input  logic                clk,
  input  logic                reset,
  input  logic                io_ena,
  input  logic                io_strobe,
  input  osd_pkg::host_word_t io_din,
  output logic                io_wait,
  output osd_pkg::host_word_t io_dout,
  input  osd_pkg::buf_byte_t  rd_byte,
  osd_cmd_if.driver           cmd_bus
);

  osd_pkg::host_state_t state;
  logic [2:0] wait_timer;
  logic wait_q;
  logic rx_pending;
  logic rx_q;
  logic is_cmd_q;
  osd_pkg::host_word_t word_q;
  osd_pkg::buf_byte_t dout_q;
  osd_pkg::cmd_code_t cmd_q;
  osd_pkg::dat_cnt_t dat_cnt_q;

  // --------------------------------------------------
  // transaction state, cleared whenever io_ena drops
  // --------------------------------------------------
  always_ff @(posedge clk) begin
    if (reset || !io_ena) begin
      state <= osd_pkg::ST_IDLE;
      wait_q <= 1'b0;
      wait_timer <= '0;
      rx_pending <= 1'b0;
      rx_q <= 1'b0;
      is_cmd_q <= 1'b0;
      dout_q <= '0;
    end else begin
      // strobe -> pending -> rx, so rx lands two cycles after the strobe
      rx_q <= rx_pending;
      if (io_strobe) begin
        // first word of a transaction is the command
        state <= (state == osd_pkg::ST_IDLE) ? osd_pkg::ST_CMD : osd_pkg::ST_DATA;
        is_cmd_q <= (state == osd_pkg::ST_IDLE);
        rx_pending <= 1'b1;
        wait_q <= 1'b1;
        wait_timer <= 3'(osd_pkg::WAIT_CYCLES - 1);
      end else begin
        rx_pending <= 1'b0;
        if (wait_timer != 3'd0) begin
          wait_timer <= wait_timer - 3'd1;
        end else begin
          wait_q <= 1'b0;
        end
      end
      // read byte for this word, held until the next one
      if (rx_q) begin
        dout_q <= rd_byte;
      end
    end
  end

  // word payload
  always_ff @(posedge clk) begin
    if (io_ena && io_strobe) begin
      word_q <= io_din;
    end
  end

  // command code and data word count survive an enable drop
  always_ff @(posedge clk) begin
    if (reset) begin
      cmd_q <= osd_pkg::cmd_code_t'(6'd0);
      dat_cnt_q <= '0;
    end else if (rx_q) begin
      if (is_cmd_q) begin
        cmd_q <= osd_pkg::cmd_code_t'(word_q[7:2]);
        dat_cnt_q <= '0;
      end else if (dat_cnt_q != osd_pkg::DAT_CNT_MAX) begin
        dat_cnt_q <= dat_cnt_q + 3'd1;
      end
    end
  end

  assign io_wait = wait_q && io_ena;
  assign io_dout = io_ena ? {8'h00, dout_q} : '0;

  assign cmd_bus.rx = rx_q;
  assign cmd_bus.is_cmd = is_cmd_q;
  assign cmd_bus.word = word_q;
  assign cmd_bus.cmd = cmd_q;
  assign cmd_bus.dat_cnt = dat_cnt_q;

  // host protocol, strobe only while wait is low
  a_no_strobe_in_wait: assert property (@(posedge clk) disable iff (reset)
    io_ena && io_strobe |-> !wait_q);

  // words are at least WAIT_CYCLES apart, so rx never doubles up
  a_rx_single: assert property (@(posedge clk) disable iff (reset)
    rx_q |=> !rx_q);

endmodule

//--- hw/osd_beam_counter.sv
// local beam position; sol and sof must come from the same clk domain, one cycle wide
`timescale 1ns/1ps

module osd_beam_counter (
  input  logic            clk,
  input  logic            reset,
  input  logic            sol,
  input  logic            sof,
  output osd_pkg::hbeam_t hbeam,
  output osd_pkg::vbeam_t vbeam
);

  // --------------------------------------------------
  // horizontal count, clk cycles since start of line
  // --------------------------------------------------
  always_ff @(posedge clk) begin
    if (reset) begin
      hbeam <= '0;
    end else if (sol) begin
      hbeam <= '0;
    end else begin
      // wraps on very long lines
      hbeam <= hbeam + 11'd1;
    end
  end

  // --------------------------------------------------
  // vertical count, lines since start of frame
  // --------------------------------------------------
  always_ff @(posedge clk) begin
    if (reset) begin
      vbeam <= '0;
    end else if (sof) begin
      // sof wins over a coincident sol
      vbeam <= '0;
    end else if (sol) begin
      vbeam <= vbeam + 9'd1;
    end
  end

  // sof is expected on a line boundary
  a_sof_at_line_start: assert property (@(posedge clk) disable iff (reset)
    sof |-> sol || $past(sol));

endmodule

//--- hw/osd_config_regs.sv
// control and video config registers, loaded by data word 0 only; read byte is combinational
`timescale 1ns/1ps

module osd_config_regs (
  input  logic                clk,
  input  logic                reset,
  osd_cmd_if.receiver         cmd_bus,
  input  osd_pkg::buf_byte_t  osd_ctrl,
  output osd_pkg::buf_byte_t  rd_byte,
  output logic                osd_enable,
  output logic                key_disable,
  output logic                usrrst,
  output logic                cpurst,
  output logic                cpuhlt,
  output osd_pkg::video_cfg_t video_cfg
);

  logic wr_first;
  logic [1:0] ver_idx;

  // first data word after a command
  assign wr_first = cmd_bus.rx && !cmd_bus.is_cmd && (cmd_bus.dat_cnt == 3'd0);

  // --------------------------------------------------
  // register writes
  // --------------------------------------------------
  always_ff @(posedge clk) begin
    if (reset) begin
      // core held in reset and halted until the host releases it
      cpuhlt <= 1'b1;
      cpurst <= 1'b1;
      usrrst <= 1'b0;
      key_disable <= 1'b0;
      osd_enable <= 1'b0;
      video_cfg <= '0;
    end else if (wr_first) begin
      case (cmd_bus.cmd)
        osd_pkg::CMD_RESET_CTRL: begin
          // H R B -> halt, cpu reset, user reset
          {cpuhlt, cpurst, usrrst} <= cmd_bus.word[2:0];
        end
        osd_pkg::CMD_OSD_CTRL: begin
          {key_disable, osd_enable} <= cmd_bus.word[1:0];
        end
        osd_pkg::CMD_VIDEO_CFG: begin
          video_cfg <= cmd_bus.word[11:0];
        end
        default: begin
          // buffer writes and reads leave the registers alone
        end
      endcase
    end
  end

  // --------------------------------------------------
  // read data
  // --------------------------------------------------

  // counts 3 and 4 both return the minion byte
  assign ver_idx = (cmd_bus.dat_cnt >= 3'd3) ? 2'd3 : cmd_bus.dat_cnt[1:0];

  always_comb begin
    if (cmd_bus.cmd == osd_pkg::CMD_VERSION) begin
      rd_byte = osd_pkg::VERSION_BYTES[ver_idx];
    end else begin
      // default read-back is the keyboard control code
      rd_byte = osd_ctrl;
    end
  end

  // registers only move on a received host word
  a_write_needs_rx: assert property (@(posedge clk) disable iff (reset)
    !cmd_bus.rx |=> $stable({cpuhlt, cpurst, usrrst, key_disable, osd_enable, video_cfg}));

endmodule

//--- hw/osd_video_buffer.sv
// 2048 x 8 character buffer, one write and one read port; contents are not cleared by reset
`timescale 1ns/1ps

module osd_video_buffer (
  input  logic               clk,
  input  logic               reset,
  osd_cmd_if.receiver        cmd_bus,
  input  osd_pkg::buf_addr_t rd_addr,
  output osd_pkg::buf_byte_t rd_data
);

  osd_pkg::buf_byte_t mem [0:2047];
  osd_pkg::buf_addr_t wr_addr;
  logic wr_armed;
  logic line_word;
  logic wr_en;

  // line number word of a buffer write command
  assign line_word = cmd_bus.rx && !cmd_bus.is_cmd
                     && (cmd_bus.cmd == osd_pkg::CMD_OSD_BUFFER)
                     && (cmd_bus.dat_cnt == osd_pkg::BUF_LINE_WORD);

  // every later data word stores its low byte
  assign wr_en = cmd_bus.rx && !cmd_bus.is_cmd && wr_armed && !line_word;

  // --------------------------------------------------
  // write address counter
  // --------------------------------------------------
  always_ff @(posedge clk) begin
    if (reset) begin
      wr_armed <= 1'b0;
      wr_addr <= '0;
    end else if (cmd_bus.rx && cmd_bus.is_cmd) begin
      wr_armed <= 1'b0;
    end else if (line_word) begin
      // each line is 256 bytes
      wr_addr <= {cmd_bus.word[2:0], 8'h00};
      wr_armed <= 1'b1;
    end else if (wr_en) begin
      wr_addr <= wr_addr + 11'd1;
    end
  end

  // --------------------------------------------------
  // storage, maps to a dual port block RAM
  // --------------------------------------------------
  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_addr] <= cmd_bus.word[7:0];
    end
  end

  // registered video read
  always_ff @(posedge clk) begin
    rd_data <= mem[rd_addr];
  end

endmodule

//--- hw/osd_pixel_gen.sv
// OSD overlay at half clk; outputs lag the beam counters by 2 cycles, enable takes effect at sof
`timescale 1ns/1ps

module osd_pixel_gen (
  input  logic               clk,
  input  logic               reset,
  input  logic               sof,
  input  osd_pkg::hbeam_t    hbeam,
  input  osd_pkg::vbeam_t    vbeam,
  input  logic               osd_enable,
  output osd_pkg::buf_addr_t rd_addr,
  input  osd_pkg::buf_byte_t rd_data,
  output logic               osd_blank,
  output logic               osd_pixel
);

  logic [9:0] hpos;
  logic [9:0] hoff;
  osd_pkg::vbeam_t voff;
  logic hwin;
  logic vwin;
  logic osd_en_q;
  logic win_q;
  logic [2:0] bit_q;

  // --------------------------------------------------
  // window decode
  // --------------------------------------------------

  // one OSD pixel per two clk cycles
  assign hpos = hbeam[10:1];
  assign hoff = hpos - osd_pkg::OSD_H_START;
  assign voff = vbeam - osd_pkg::OSD_V_START;

  assign hwin = (hpos >= osd_pkg::OSD_H_START)
                && (hpos < osd_pkg::OSD_H_START + osd_pkg::OSD_H_WIDTH);
  assign vwin = (vbeam >= osd_pkg::OSD_V_START)
                && (vbeam < osd_pkg::OSD_V_START + osd_pkg::OSD_V_HEIGHT);

  // character row of 8 lines, 256 columns per row
  assign rd_addr = {voff[5:3], hoff[7:0]};

  // enable changes only between frames
  always_ff @(posedge clk) begin
    if (reset) begin
      osd_en_q <= 1'b0;
    end else if (sof) begin
      osd_en_q <= osd_enable;
    end
  end

  // stage 1 runs alongside the buffer read, stage 2 picks the bit
  always_ff @(posedge clk) begin
    if (reset) begin
      win_q <= 1'b0;
      osd_blank <= 1'b0;
      osd_pixel <= 1'b0;
    end else begin
      win_q <= hwin && vwin && osd_en_q;
      osd_blank <= win_q;
      osd_pixel <= win_q && rd_data[bit_q];
    end
  end

  // bit within the character byte is the line inside the row
  always_ff @(posedge clk) begin
    bit_q <= voff[2:0];
  end

endmodule

//--- hw/osd_controller.sv
// OSD controller top; host port, config outputs and overlay video, all on one clk with no enables
`timescale 1ns/1ps

module osd_controller (
  input  logic                clk,
  input  logic                reset,
  // video timing
  input  logic                sol,
  input  logic                sof,
  // keyboard control code for default read-back
  input  osd_pkg::buf_byte_t  osd_ctrl,
  // host port
  input  logic                io_ena,
  input  logic                io_strobe,
  output logic                io_wait,
  input  osd_pkg::host_word_t io_din,
  output osd_pkg::host_word_t io_dout,
  // overlay
  output logic                osd_blank,
  output logic                osd_pixel,
  // control
  output logic                osd_enable,
  output logic                key_disable,
  output logic                usrrst,
  output logic                cpurst,
  output logic                cpuhlt,
  // video config fields
  output logic [1:0]          blver,
  output logic [1:0]          ar,
  output logic [1:0]          dither,
  output logic [1:0]          hr_filter,
  output logic [1:0]          lr_filter,
  output logic [1:0]          scanline
);

  osd_cmd_if cmd_bus ();

  osd_pkg::buf_byte_t rd_byte;
  osd_pkg::video_cfg_t video_cfg;
  osd_pkg::hbeam_t hbeam;
  osd_pkg::vbeam_t vbeam;
  osd_pkg::buf_addr_t buf_rd_addr;
  osd_pkg::buf_byte_t buf_rd_data;

  // --------------------------------------------------
  // host side
  // --------------------------------------------------
  osd_host_fsm i_host_fsm (
    .clk       (clk),
    .reset     (reset),
    .io_ena    (io_ena),
    .io_strobe (io_strobe),
    .io_din    (io_din),
    .io_wait   (io_wait),
    .io_dout   (io_dout),
    .rd_byte   (rd_byte),
    .cmd_bus   (cmd_bus.driver)
  );

  osd_config_regs i_config_regs (
    .clk         (clk),
    .reset       (reset),
    .cmd_bus     (cmd_bus.receiver),
    .osd_ctrl    (osd_ctrl),
    .rd_byte     (rd_byte),
    .osd_enable  (osd_enable),
    .key_disable (key_disable),
    .usrrst      (usrrst),
    .cpurst      (cpurst),
    .cpuhlt      (cpuhlt),
    .video_cfg   (video_cfg)
  );

  assign {blver, ar, dither, hr_filter, lr_filter, scanline} = video_cfg;

  // --------------------------------------------------
  // video side
  // --------------------------------------------------
  osd_video_buffer i_video_buffer (
    .clk     (clk),
    .reset   (reset),
    .cmd_bus (cmd_bus.receiver),
    .rd_addr (buf_rd_addr),
    .rd_data (buf_rd_data)
  );

  osd_beam_counter i_beam_counter (
    .clk   (clk),
    .reset (reset),
    .sol   (sol),
    .sof   (sof),
    .hbeam (hbeam),
    .vbeam (vbeam)
  );

  osd_pixel_gen i_pixel_gen (
    .clk        (clk),
    .reset      (reset),
    .sof        (sof),
    .hbeam      (hbeam),
    .vbeam      (vbeam),
    .osd_enable (osd_enable),
    .rd_addr    (buf_rd_addr),
    .rd_data    (buf_rd_data),
    .osd_blank  (osd_blank),
    .osd_pixel  (osd_pixel)
  );

endmodule

//--- tb/tb_osd_controller.sv
// testbench for osd_controller; run from the project root so tb/osd_testdata.txt is found
`timescale 1ns/1ps

module tb_osd_controller;

  // clk cycles per scanned line, covers the whole OSD window
  localparam int LINE_CYCLES = 1500;
  localparam int SCAN_LINES = 8;

  logic clk;
  logic reset;
  logic sol;
  logic sof;
  osd_pkg::buf_byte_t osd_ctrl;
  logic io_ena;
  logic io_strobe;
  logic io_wait;
  osd_pkg::host_word_t io_din;
  osd_pkg::host_word_t io_dout;
  logic osd_blank;
  logic osd_pixel;
  logic osd_enable;
  logic key_disable;
  logic usrrst;
  logic cpurst;
  logic cpuhlt;
  logic [1:0] blver;
  logic [1:0] ar;
  logic [1:0] dither;
  logic [1:0] hr_filter;
  logic [1:0] lr_filter;
  logic [1:0] scanline;

  int errors = 0;
  int checks = 0;
  int step = 0;
  int cycles = 0;
  // replaced once the data file is loaded
  int limit = 100000;
  integer seed;

  // operations from the data file
  byte op_q[$];
  logic [31:0] arg_a[$];
  logic [31:0] arg_b[$];

  // expected character buffer contents
  osd_pkg::buf_byte_t model [0:2047];

  osd_controller i_dut (
    .clk         (clk),
    .reset       (reset),
    .sol         (sol),
    .sof         (sof),
    .osd_ctrl    (osd_ctrl),
    .io_ena      (io_ena),
    .io_strobe   (io_strobe),
    .io_wait     (io_wait),
    .io_din      (io_din),
    .io_dout     (io_dout),
    .osd_blank   (osd_blank),
    .osd_pixel   (osd_pixel),
    .osd_enable  (osd_enable),
    .key_disable (key_disable),
    .usrrst      (usrrst),
    .cpurst      (cpurst),
    .cpuhlt      (cpuhlt),
    .blver       (blver),
    .ar          (ar),
    .dither      (dither),
    .hr_filter   (hr_filter),
    .lr_filter   (lr_filter),
    .scanline    (scanline)
  );

  // 20 ns clock
  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // run limit, set from the number and kind of operations
  always @(posedge clk) begin
    cycles++;
    if (cycles >= limit) begin
      $display("timeout, test did not finish within %0d cycles", limit);
      $display("Some tests failed");
      $finish;
    end
  end

  // --------------------------------------------------
  // compare tasks, expected before actual
  // --------------------------------------------------
  task automatic check_word(input string name, input osd_pkg::host_word_t exp,
                            input osd_pkg::host_word_t act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("FAILED step %0d %s: expected %h, actual %h", step, name, exp, act);
    end
  endtask

  task automatic check_cfg(input string name, input osd_pkg::video_cfg_t exp,
                           input osd_pkg::video_cfg_t act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("FAILED step %0d %s: expected %h, actual %h", step, name, exp, act);
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("FAILED step %0d %s: expected %b, actual %b", step, name, exp, act);
    end
  endtask

  // --------------------------------------------------
  // host port
  // --------------------------------------------------

  // one word; io_wait must stay up for exactly WAIT_CYCLES samples
  task automatic write_word(input osd_pkg::host_word_t w);
    int n_wait;
    while (io_wait) begin
      @(negedge clk);
    end
    io_din = w;
    io_strobe = 1'b1;
    @(negedge clk);
    io_strobe = 1'b0;
    n_wait = 0;
    while (io_wait) begin
      n_wait++;
      @(negedge clk);
    end
    check_word("io_wait cycles", osd_pkg::host_word_t'(osd_pkg::WAIT_CYCLES),
               osd_pkg::host_word_t'(n_wait));
  endtask

  // host port idles with io_ena low, the next word is a command again
  task automatic drop_enable();
    io_ena = 1'b0;
    @(negedge clk);
    @(negedge clk);
    check_word("io_dout with io_ena low", '0, io_dout);
    check_bit("io_wait with io_ena low", 1'b0, io_wait);
    io_ena = 1'b1;
    @(negedge clk);
  endtask

  // status bits are {cpuhlt, cpurst, usrrst, key_disable, osd_enable}
  task automatic check_status(input logic [4:0] st, input osd_pkg::video_cfg_t cfg);
    check_bit("cpuhlt", st[4], cpuhlt);
    check_bit("cpurst", st[3], cpurst);
    check_bit("usrrst", st[2], usrrst);
    check_bit("key_disable", st[1], key_disable);
    check_bit("osd_enable", st[0], osd_enable);
    check_cfg("video_cfg", cfg, {blver, ar, dither, hr_filter, lr_filter, scanline});
  endtask

  // 256 random bytes after the line word of a buffer command
  task automatic fill_line(input logic [2:0] line);
    int i;
    int rnd;
    osd_pkg::buf_byte_t b;
    for (i = 0; i < 256; i++) begin
      rnd = $random(seed);
      b = rnd[7:0];
      model[{line, 8'(i)}] = b;
      write_word({8'h00, b});
    end
  endtask

  // --------------------------------------------------
  // video scan
  // --------------------------------------------------
  task automatic scan_frame(input logic en);
    int i;
    int c;
    int h;
    int v;
    int hp;
    int h_lo;
    int h_hi;
    int v_lo;
    int v_hi;
    logic [1:0] exp_blank;
    logic [1:0] exp_pixel;
    logic win;
    logic pix;
    osd_pkg::buf_addr_t addr;
    logic [2:0] bsel;
    h_lo = int'(osd_pkg::OSD_H_START);
    h_hi = h_lo + int'(osd_pkg::OSD_H_WIDTH);
    v_lo = int'(osd_pkg::OSD_V_START);
    v_hi = v_lo + int'(osd_pkg::OSD_V_HEIGHT);
    // outputs still show positions before the first scanned one, all outside the window
    exp_blank = '0;
    exp_pixel = '0;
    sof = 1'b1;
    sol = 1'b1;
    @(negedge clk);
    sof = 1'b0;
    // short lines down to OSD line 16
    for (i = 0; i < v_lo + 16; i++) begin
      sol = 1'b0;
      @(negedge clk);
      sol = 1'b1;
      @(negedge clk);
    end
    sol = 1'b0;
    for (c = 0; c < SCAN_LINES * LINE_CYCLES + 2; c++) begin
      h = c % LINE_CYCLES;
      v = v_lo + 16 + c / LINE_CYCLES;
      // outputs belong to the position two cycles back
      check_bit($sformatf("osd_blank scan cycle %0d", c), exp_blank[1], osd_blank);
      check_bit($sformatf("osd_pixel scan cycle %0d", c), exp_pixel[1], osd_pixel);
      // one OSD pixel per two clk cycles
      hp = h / 2;
      win = en && (hp >= h_lo) && (hp < h_hi) && (v >= v_lo) && (v < v_hi);
      pix = 1'b0;
      if (win) begin
        addr = osd_pkg::buf_addr_t'((v - v_lo) / 8 * 256 + (hp - h_lo));
        bsel = 3'((v - v_lo) % 8);
        pix = model[addr][bsel];
      end
      exp_blank = {exp_blank[0], win};
      exp_pixel = {exp_pixel[0], pix};
      sol = (h == LINE_CYCLES - 1);
      @(negedge clk);
    end
    sol = 1'b0;
  endtask

  // --------------------------------------------------
  // data file
  // --------------------------------------------------
  task automatic load_tests(output logic ok);
    int fd;
    int n;
    int n_fill;
    int n_scan;
    byte op;
    logic [31:0] a;
    logic [31:0] b;
    logic [8*160-1:0] rest;
    logic done;
    ok = 1'b0;
    n_fill = 0;
    n_scan = 0;
    done = 1'b0;
    fd = $fopen("tb/osd_testdata.txt", "r");
    if (fd != 0) begin
      ok = 1'b1;
      while (!done) begin
        n = $fscanf(fd, " %c", op);
        if (n != 1) begin
          done = 1'b1;
        end else if (op == "#") begin
          n = $fgets(rest, fd);
        end else begin
          a = '0;
          b = '0;
          if (op == "E") begin
            n = $fscanf(fd, " %h %h", a, b);
          end else if (op != "D") begin
            n = $fscanf(fd, " %h", a);
          end
          op_q.push_back(op);
          arg_a.push_back(a);
          arg_b.push_back(b);
          if (op == "B") n_fill++;
          if (op == "P") n_scan++;
        end
      end
      $fclose(fd);
      // reset, about 20 cycles per operation, buffer fills and scans
      limit = 40 + op_q.size() * 20 + n_fill * 256 * 10 + n_scan * 9 * LINE_CYCLES;
    end
  endtask

  task automatic run_tests();
    int k;
    for (k = 0; k < op_q.size(); k++) begin
      step = k + 1;
      case (op_q[k])
        "W": write_word(arg_a[k][15:0]);
        "D": drop_enable();
        "K": osd_ctrl = arg_a[k][7:0];
        "R": check_word("read byte", {8'h00, arg_a[k][7:0]}, io_dout);
        "E": check_status(arg_a[k][4:0], arg_b[k][11:0]);
        "B": fill_line(arg_a[k][2:0]);
        "P": scan_frame(arg_a[k][0]);
        default: begin
          errors++;
          $display("unknown operation %c in the test data", op_q[k]);
        end
      endcase
    end
  endtask

  // --------------------------------------------------
  // main sequence
  // --------------------------------------------------
  initial begin
    logic ok;
    reset = 1'b1;
    sol = 1'b0;
    sof = 1'b0;
    osd_ctrl = '0;
    io_ena = 1'b0;
    io_strobe = 1'b0;
    io_din = '0;
    seed = 32'hcf477fd6;
    load_tests(ok);
    if (!ok) begin
      errors++;
      $display("could not open tb/osd_testdata.txt");
    end
    repeat (10) @(negedge clk);
    reset = 1'b0;
    @(negedge clk);
    // host port idle and overlay off straight out of reset
    check_bit("io_wait after reset", 1'b0, io_wait);
    check_word("io_dout with io_ena low", '0, io_dout);
    check_bit("osd_blank after reset", 1'b0, osd_blank);
    io_ena = 1'b1;
    @(negedge clk);
    run_tests();
    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

//--- tb/osd_testdata.txt
# op [value [value]] in hex: W host word, D drop io_ena, K osd_ctrl input, R io_dout byte
# E status {cpuhlt,cpurst,usrrst,key_disable,osd_enable} and video_cfg, B fill line, P scan enable
E 18 000
K 5a
# reset control, user reset only
W 0008
W 0001
R 5a
E 04 000
D
# osd control, key disable and osd enable
W 0028
W 0003
R 5a
E 07 000
D
# video configuration
W 0034
W 0abc
R 5a
E 07 abc
D
# unlisted command changes nothing
W 00fc
W 0fff
R 5a
E 07 abc
D
# version read, last byte repeats
W 0088
W 0000
R 01
W 0000
R 03
W 0000
R 05
W 0000
R 02
W 0000
R 02
D
# halt and reset the core
W 0008
W 0006
R 5a
E 1b abc
D
# buffer line 2, then scan with the OSD on
W 000c
W 0000
W 0000
W 0000
W 0002
B 2
D
P 1
# OSD off before the next frame
W 0028
W 0000
E 18 abc
D
P 0

//--- verilog.f
hw/osd_pkg.sv
hw/osd_cmd_if.sv
hw/osd_host_fsm.sv
hw/osd_beam_counter.sv
hw/osd_config_regs.sv
hw/osd_video_buffer.sv
hw/osd_pixel_gen.sv
hw/osd_controller.sv
tb/tb_osd_controller.sv

//--- Makefile
TOP = tb_osd_controller

all: run

build:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f verilog.f --Mdir obj_dir -o sim

run: build
	./obj_dir/sim | tee sim.log
	grep -q "All tests passed" sim.log

lint:
	verilator --lint-only --timing --top-module $(TOP) -f verilog.f

clean:
	rm -rf obj_dir sim.log

.PHONY: all build run lint clean
